/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module sha512_axil_tb \
		-f sha512_axil.f --Mdir obj_dir -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* dv/sha512_axil_asserts.sv */
`timescale 1ns/100ps

module sha512_axil_asserts (
  input logic                   clk,
  input logic                   reset_n,
  input logic                   awready,
  input logic                   arready,
  input logic                   bvalid,
  input logic                   bready,
  input sha512_pkg::axil_resp_e bresp,
  input logic                   rvalid,
  input logic                   rready,
  input logic [31:0]            rdata,
  input sha512_pkg::axil_resp_e rresp,
  input logic                   notif_intr
);

  // Write response held until bready
  b_hold: assert property (@(posedge clk) disable iff (!reset_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid or bresp changed before bready");

  // Read response held until rready
  r_hold: assert property (@(posedge clk) disable iff (!reset_n)
    rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
    else $error("rvalid, rresp or rdata changed before rready");

  no_accept_pending: assert property (@(posedge clk) disable iff (!reset_n)
    (bvalid || rvalid) |-> !(awready || arready))
    else $error("new transaction accepted while a response is pending");

  intr_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !notif_intr)
    else $error("notif_intr high after reset");

endmodule

/* dv/sha512_axil_tb.sv */
`timescale 1ns/100ps

module sha512_axil_tb;
  import sha512_pkg::*;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_POLL} tb_op_e;

  typedef struct {
    tb_op_e     op;
    logic [11:0] addr;
    reg_data_t  data;
    reg_data_t  exp;
    reg_data_t  mask;
    axil_resp_e resp;
    logic       intr;
  } tb_entry_t;

  localparam int AXIL_ADDR_W = 12;
  // Four hashes of ~100 cycles plus ~350 bus operations of ~4 cycles with a wide margin
  localparam int TIMEOUT_CYCLES = 5000;

  // FIPS 180-4 example digests
  localparam sha512_digest_t ABC_DIGEST = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f
  };
  localparam sha512_digest_t TWO_BLOCK_DIGEST = {
    64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1, 64'h7299aeadb6889018,
    64'h501d289e4900f7e4, 64'h331b99dec4b5433a, 64'hc7d329eeb6dd2654, 64'h5e96e55b874be909
  };

  logic                   clk;
  logic                   reset_n;
  logic                   awvalid;
  logic                   awready;
  logic [AXIL_ADDR_W-1:0] awaddr;
  logic                   wvalid;
  logic                   wready;
  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   bvalid;
  logic                   bready;
  axil_resp_e             bresp;
  logic                   arvalid;
  logic                   arready;
  logic [AXIL_ADDR_W-1:0] araddr;
  logic                   rvalid;
  logic                   rready;
  logic [31:0]            rdata;
  axil_resp_e             rresp;
  logic                   notif_intr;

  tb_entry_t     table_q [$];
  logic          cur_intr;
  int            seed;
  int            cycle_count = 0;
  logic [2047:0] two_msg;

  tb_clkgen u_clkgen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  sha512_axil #(
    .AXIL_ADDR_W (AXIL_ADDR_W)
  ) u_sha512_axil (
    .clk        (clk),
    .reset_n    (reset_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .notif_intr (notif_intr)
  );

  bind sha512_axil sha512_axil_asserts u_asserts (.*);

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_word(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s data 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s response %s, expected %s",
               $time, what, got.name(), exp.name());
      $display("CHECKS FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_intr(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s notif_intr %b, expected %b", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "interrupt mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // AXI4-Lite manager tasks start and end 1 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic bus_write(input logic [11:0] addr, input reg_data_t data,
                           output axil_resp_e resp);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // bready held back one cycle so the response has to wait
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic bus_read(input logic [11:0] addr, output reg_data_t data,
                          output axil_resp_e resp);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    // rready held back one cycle so the response has to wait
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Table construction
  // ----------------------------------------------------------------------
  function automatic logic [11:0] word_addr(input logic [8:0] base, input int idx);
    return 12'(base) + 12'(4 * idx);
  endfunction

  task automatic add_entry(input tb_op_e op, input logic [11:0] addr, input reg_data_t data,
                           input reg_data_t exp, input reg_data_t mask, input axil_resp_e resp);
    tb_entry_t e;
    e.op   = op;
    e.addr = addr;
    e.data = data;
    e.exp  = exp;
    e.mask = mask;
    e.resp = resp;
    e.intr = cur_intr;
    table_q.push_back(e);
  endtask

  task automatic add_write(input logic [11:0] addr, input reg_data_t data);
    add_entry(OP_WRITE, addr, data, '0, '0, OKAY);
  endtask

  task automatic add_read(input logic [11:0] addr, input reg_data_t exp);
    add_entry(OP_READ, addr, '0, exp, '1, OKAY);
  endtask

  // Completion leaves ready and valid set and raises the done flag
  task automatic add_poll();
    cur_intr = 1'b1;
    add_entry(OP_POLL, 12'(ADDR_STATUS), '0, 32'h3, 32'h3, OKAY);
  endtask

  task automatic add_block_writes(input sha512_block_t blk);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      add_write(word_addr(ADDR_BLOCK, i), blk[1023 - 32*i -: 32]);
    end
  endtask

  task automatic add_digest_reads(input sha512_digest_t d);
    logic [511:0] flat;
    flat = d;
    for (int i = 0; i < DIGEST_WORDS; i++) begin
      add_read(word_addr(ADDR_DIGEST, i), flat[511 - 32*i -: 32]);
    end
  endtask

  // "abc" padded to one block with its 24-bit length
  function automatic sha512_block_t abc_block();
    sha512_block_t b;
    b = '0;
    b[1023:1000] = "abc";
    b[999] = 1'b1;
    b[127:0] = 128'd24;
    return b;
  endfunction

  // 896-bit message of 14 groups of 8 letters padded to two blocks
  function automatic logic [2047:0] two_block_msg();
    logic [2047:0] m;
    m = '0;
    for (int k = 0; k < 112; k++) begin
      m[2047 - 8*k -: 8] = 8'(97 + k / 8 + k % 8);
    end
    m[1151] = 1'b1;
    m[127:0] = 128'd896;
    return m;
  endfunction

  task automatic apply_entry(input tb_entry_t e, input int idx);
    reg_data_t  rd;
    axil_resp_e resp;
    string      what;
    what = $sformatf("entry %0d addr 0x%03h", idx, e.addr);
    rd = '0;
    case (e.op)
      OP_WRITE: begin
        bus_write(e.addr, e.data, resp);
        check_resp(resp, e.resp, what);
      end
      OP_READ: begin
        bus_read(e.addr, rd, resp);
        check_resp(resp, e.resp, what);
        check_word(rd & e.mask, e.exp & e.mask, what);
      end
      default: begin
        while (!rd[0]) begin
          bus_read(e.addr, rd, resp);
          check_resp(resp, e.resp, what);
        end
        check_word(rd & e.mask, e.exp & e.mask, what);
      end
    endcase
    check_intr(notif_intr, e.intr, what);
  endtask

  initial begin
    awvalid  = 1'b0;
    awaddr   = '0;
    wvalid   = 1'b0;
    wdata    = '0;
    wstrb    = 4'hf;
    bready   = 1'b0;
    arvalid  = 1'b0;
    araddr   = '0;
    rready   = 1'b0;
    cur_intr = 1'b0;
    seed     = 32'hdce8_5fc1;
    two_msg  = two_block_msg();

    // Single block
    add_block_writes(abc_block());
    add_write(12'(ADDR_CTRL), 32'h1);
    add_poll();
    add_digest_reads(ABC_DIGEST);

    // Interrupt clear
    add_read(12'(ADDR_INTR), 32'h1);
    cur_intr = 1'b0;
    add_write(12'(ADDR_INTR), 32'h1);
    add_read(12'(ADDR_INTR), 32'h0);

    // Two blocks chained with next
    add_block_writes(two_msg[2047:1024]);
    add_write(12'(ADDR_CTRL), 32'h1);
    add_poll();
    add_block_writes(two_msg[1023:0]);
    add_write(12'(ADDR_CTRL), 32'h2);
    add_poll();
    add_digest_reads(TWO_BLOCK_DIGEST);

    // Zeroize after a fresh hash
    add_write(12'(ADDR_CTRL), 32'h1);
    add_poll();
    cur_intr = 1'b0;
    add_write(12'(ADDR_CTRL), 32'h4);
    add_entry(OP_READ, 12'(ADDR_STATUS), '0, 32'h1, 32'h3, OKAY);
    add_digest_reads('0);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      add_read(word_addr(ADDR_BLOCK, i), '0);
    end

    // Error responses leave the block intact
    add_write(word_addr(ADDR_BLOCK, 5), 32'h5a5a_c3c3);
    add_entry(OP_READ, 12'h004, '0, '0, '0, SLVERR);
    add_entry(OP_WRITE, 12'(ADDR_STATUS), 32'h3, '0, '0, SLVERR);
    add_entry(OP_READ, 12'(ADDR_CTRL), '0, '0, '0, SLVERR);
    add_read(word_addr(ADDR_BLOCK, 5), 32'h5a5a_c3c3);

    // Random block words read back in a scrambled order
    begin
      reg_data_t rand_words [BLOCK_WORDS];
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        rand_words[i] = $random(seed);
        add_write(word_addr(ADDR_BLOCK, i), rand_words[i]);
      end
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        add_read(word_addr(ADDR_BLOCK, (7 * i) % BLOCK_WORDS),
                 rand_words[(7 * i) % BLOCK_WORDS]);
      end
    end

    @(posedge reset_n);
    @(posedge clk);
    #1;
    foreach (table_q[i]) begin
      apply_entry(table_q[i], i);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* dv/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for 4 rising edges, released just after the last one
  initial begin
    reset_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;
  end

endmodule

/* sha512_axil.f */
verilog/sha512_pkg.sv
verilog/sha512_axil_slave.sv
verilog/sha512_regs.sv
verilog/sha512_schedule.sv
verilog/sha512_core.sv
verilog/sha512_axil.sv
dv/tb_clkgen.sv
dv/sha512_axil_asserts.sv
dv/sha512_axil_tb.sv

/* verilog/sha512_axil.sv */
`timescale 1ns/100ps

module sha512_axil #(
  parameter int AXIL_ADDR_W = 12
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [AXIL_ADDR_W-1:0] awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [31:0]            wdata,
  // Byte strobes are ignored, every write updates a full register
  input  logic [3:0]             wstrb,
  output logic                   bvalid,
  input  logic                   bready,
  output sha512_pkg::axil_resp_e bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [AXIL_ADDR_W-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [31:0]            rdata,
  output sha512_pkg::axil_resp_e rresp,
  output logic                   notif_intr
);
  import sha512_pkg::*;

  reg_req_t       reg_req;
  reg_rsp_t       reg_rsp;
  core_cmd_t      cmd;
  sha512_block_t  block;
  logic           core_ready;
  logic           core_digest_valid;
  sha512_digest_t core_digest;

  sha512_axil_slave #(
    .AXIL_ADDR_W (AXIL_ADDR_W)
  ) u_slave (
    .clk     (clk),
    .reset_n (reset_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .reg_req (reg_req),
    .reg_rsp (reg_rsp)
  );

  sha512_regs u_regs (
    .clk               (clk),
    .reset_n           (reset_n),
    .reg_req           (reg_req),
    .reg_rsp           (reg_rsp),
    .cmd               (cmd),
    .block             (block),
    .core_ready        (core_ready),
    .core_digest_valid (core_digest_valid),
    .core_digest       (core_digest),
    .notif_intr        (notif_intr)
  );

  sha512_core u_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .cmd          (cmd),
    .block        (block),
    .ready        (core_ready),
    .digest_valid (core_digest_valid),
    .digest       (core_digest)
  );

endmodule

/* verilog/sha512_axil_slave.sv */
`timescale 1ns/100ps

module sha512_axil_slave #(
  parameter int AXIL_ADDR_W = 12
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [AXIL_ADDR_W-1:0] awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [31:0]            wdata,
  output logic                   bvalid,
  input  logic                   bready,
  output sha512_pkg::axil_resp_e bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [AXIL_ADDR_W-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output logic [31:0]            rdata,
  output sha512_pkg::axil_resp_e rresp,
  output sha512_pkg::reg_req_t   reg_req,
  input  sha512_pkg::reg_rsp_t   reg_rsp
);
  import sha512_pkg::*;

  axil_state_e state_q;
  axil_resp_e  resp_q;
  reg_data_t   rdata_q;
  logic        idle;
  logic        wr_accept;
  logic        rd_accept;

  assign idle = (state_q == AXIL_IDLE);
  // Address and data must arrive together; a read waits behind any write
  assign wr_accept = idle && awvalid && wvalid;
  assign rd_accept = idle && arvalid && !awvalid && !wvalid;

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  // Single-cycle register access, upper address bits are dropped
  always_comb begin
    reg_req.valid = wr_accept || rd_accept;
    reg_req.write = wr_accept;
    reg_req.addr  = wr_accept ? awaddr[8:0] : araddr[8:0];
    reg_req.wdata = wdata;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= AXIL_IDLE;
      resp_q  <= OKAY;
    end else begin
      case (state_q)
        AXIL_IDLE: begin
          if (wr_accept || rd_accept) begin
            state_q <= wr_accept ? AXIL_WRESP : AXIL_RRESP;
            resp_q  <= reg_rsp.err ? SLVERR : OKAY;
          end
        end
        AXIL_WRESP: begin
          if (bready) begin
            state_q <= AXIL_IDLE;
          end
        end
        AXIL_RRESP: begin
          if (rready) begin
            state_q <= AXIL_IDLE;
          end
        end
        default: state_q <= AXIL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_q <= reg_rsp.rdata;
    end
  end

  // Response held until the manager takes it
  assign bvalid = (state_q == AXIL_WRESP);
  assign rvalid = (state_q == AXIL_RRESP);
  assign bresp  = resp_q;
  assign rresp  = resp_q;
  assign rdata  = rdata_q;

endmodule

/* verilog/sha512_core.sv */
`timescale 1ns/100ps

module sha512_core (
  input  logic                       clk,
  input  logic                       reset_n,
  input  sha512_pkg::core_cmd_t      cmd,
  input  sha512_pkg::sha512_block_t  block,
  output logic                       ready,
  output logic                       digest_valid,
  output sha512_pkg::sha512_digest_t digest
);
  import sha512_pkg::*;

  core_state_e    state_q;
  logic [6:0]     round_q;
  logic           from_init_q;
  logic           valid_q;
  logic           start;
  sha512_digest_t work_q;
  sha512_digest_t work_next;
  sha512_digest_t digest_q;
  sha512_digest_t chain;
  sha512_word_t   w;
  sha512_word_t   t1;
  sha512_word_t   t2;

  function automatic sha512_word_t big_sigma0(sha512_word_t x);
    return {x[27:0], x[63:28]} ^ {x[33:0], x[63:34]} ^ {x[38:0], x[63:39]};
  endfunction

  function automatic sha512_word_t big_sigma1(sha512_word_t x);
    return {x[13:0], x[63:14]} ^ {x[17:0], x[63:18]} ^ {x[40:0], x[63:41]};
  endfunction

  assign ready = (state_q == CORE_IDLE);
  assign start = ready && (cmd.init || cmd.next);
  assign chain = from_init_q ? sha512_h_init : digest_q;

  sha512_schedule u_schedule (
    .clk     (clk),
    .reset_n (reset_n),
    .load    (start),
    .advance (state_q == CORE_ROUNDS),
    .zeroize (cmd.zeroize),
    .block   (block),
    .w       (w)
  );

  // ----------------------------------------------------------------------
  // One compression round, a..h are elements 0..7
  // ----------------------------------------------------------------------
  always_comb begin
    t1 = work_q[7] + big_sigma1(work_q[4]) +
         ((work_q[4] & work_q[5]) ^ (~work_q[4] & work_q[6])) + k_table[round_q] + w;
    t2 = big_sigma0(work_q[0]) +
         ((work_q[0] & work_q[1]) ^ (work_q[0] & work_q[2]) ^ (work_q[1] & work_q[2]));
    work_next = {t1 + t2, work_q[0], work_q[1], work_q[2],
                 work_q[3] + t1, work_q[4], work_q[5], work_q[6]};
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q     <= CORE_IDLE;
      round_q     <= '0;
      from_init_q <= 1'b0;
      valid_q     <= 1'b0;
    end else if (cmd.zeroize) begin
      state_q     <= CORE_IDLE;
      round_q     <= '0;
      from_init_q <= 1'b0;
      valid_q     <= 1'b0;
    end else begin
      case (state_q)
        CORE_IDLE: begin
          if (start) begin
            state_q     <= CORE_ROUNDS;
            round_q     <= '0;
            from_init_q <= cmd.init;
            valid_q     <= 1'b0;
          end
        end
        CORE_ROUNDS: begin
          if (round_q == 7'd79) begin
            state_q <= CORE_UPDATE;
            round_q <= '0;
          end else begin
            round_q <= round_q + 7'd1;
          end
        end
        CORE_UPDATE: begin
          state_q <= CORE_IDLE;
          valid_q <= 1'b1;
        end
        default: state_q <= CORE_IDLE;
      endcase
    end
  end

  // Working variables and chained digest
  always_ff @(posedge clk) begin
    if (cmd.zeroize) begin
      work_q   <= '0;
      digest_q <= '0;
    end else if (start) begin
      work_q <= cmd.init ? sha512_h_init : digest_q;
    end else if (state_q == CORE_ROUNDS) begin
      work_q <= work_next;
    end else if (state_q == CORE_UPDATE) begin
      for (int i = 0; i < 8; i++) begin
        digest_q[i] <= chain[i] + work_q[i];
      end
    end
  end

  assign digest       = digest_q;
  assign digest_valid = valid_q;

endmodule

/* verilog/sha512_pkg.sv */
package sha512_pkg;

  typedef logic [31:0]   reg_data_t;
  typedef logic [63:0]   sha512_word_t;
  typedef logic [1023:0] sha512_block_t;
  // Element 0 is H0 and sits in the top 64 bits
  typedef sha512_word_t [0:7] sha512_digest_t;

  localparam int BLOCK_WORDS  = 32;
  localparam int DIGEST_WORDS = 16;

  // ----------------------------------------------------------------------
  // Register map, byte addresses
  // ----------------------------------------------------------------------
  localparam logic [8:0] ADDR_CTRL   = 9'h010;
  localparam logic [8:0] ADDR_STATUS = 9'h018;
  localparam logic [8:0] ADDR_INTR   = 9'h020;
  localparam logic [8:0] ADDR_BLOCK  = 9'h080;
  localparam logic [8:0] ADDR_DIGEST = 9'h100;

  typedef struct packed {
    logic       valid;
    logic       write;
    logic [8:0] addr;
    reg_data_t  wdata;
  } reg_req_t;

  typedef struct packed {
    reg_data_t rdata;
    logic      err;
  } reg_rsp_t;

  typedef struct packed {
    logic init;
    logic next;
    logic zeroize;
  } core_cmd_t;

  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} axil_resp_e;
  typedef enum logic [1:0] {CORE_IDLE, CORE_ROUNDS, CORE_UPDATE} core_state_e;
  typedef enum logic [1:0] {AXIL_IDLE, AXIL_WRESP, AXIL_RRESP} axil_state_e;

  // ----------------------------------------------------------------------
  // FIPS 180-4 constants
  // ----------------------------------------------------------------------
  localparam sha512_digest_t sha512_h_init = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  localparam sha512_word_t k_table [80] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

endpackage

/* verilog/sha512_regs.sv */
`timescale 1ns/100ps

module sha512_regs (
  input  logic                       clk,
  input  logic                       reset_n,
  input  sha512_pkg::reg_req_t       reg_req,
  output sha512_pkg::reg_rsp_t       reg_rsp,
  output sha512_pkg::core_cmd_t      cmd,
  output sha512_pkg::sha512_block_t  block,
  input  logic                       core_ready,
  input  logic                       core_digest_valid,
  input  sha512_pkg::sha512_digest_t core_digest,
  output logic                       notif_intr
);
  import sha512_pkg::*;

  reg_data_t      block_q [BLOCK_WORDS];
  sha512_digest_t digest_q;
  logic           done_q;
  logic           valid_d;
  logic           digest_rise;
  logic           wr;
  logic           aligned;
  logic           hit_ctrl;
  logic           hit_status;
  logic           hit_intr;
  logic           hit_block;
  logic           hit_digest;
  logic           unmapped;
  logic [4:0]     block_idx;
  logic [3:0]     digest_idx;
  reg_data_t      digest_word;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  assign wr         = reg_req.valid && reg_req.write;
  assign aligned    = (reg_req.addr[1:0] == 2'b00);
  assign hit_ctrl   = (reg_req.addr == ADDR_CTRL);
  assign hit_status = (reg_req.addr == ADDR_STATUS);
  assign hit_intr   = (reg_req.addr == ADDR_INTR);
  assign hit_block  = aligned && (reg_req.addr >= ADDR_BLOCK) &&
                      (reg_req.addr < ADDR_BLOCK + 9'(4 * BLOCK_WORDS));
  assign hit_digest = aligned && (reg_req.addr >= ADDR_DIGEST) &&
                      (reg_req.addr < ADDR_DIGEST + 9'(4 * DIGEST_WORDS));
  assign unmapped   = !(hit_ctrl || hit_status || hit_intr || hit_block || hit_digest);

  // Both regions are aligned to their size, so the low bits index directly
  assign block_idx  = reg_req.addr[6:2];
  assign digest_idx = reg_req.addr[5:2];

  // Even word is the upper half of a 64-bit digest word
  assign digest_word = digest_idx[0] ? digest_q[digest_idx[3:1]][31:0]
                                     : digest_q[digest_idx[3:1]][63:32];

  always_comb begin
    reg_rsp.rdata = '0;
    if (hit_status) begin
      reg_rsp.rdata = {30'd0, core_digest_valid, core_ready};
    end else if (hit_intr) begin
      reg_rsp.rdata = {31'd0, done_q};
    end else if (hit_block) begin
      reg_rsp.rdata = block_q[block_idx];
    end else if (hit_digest) begin
      reg_rsp.rdata = digest_word;
    end
    reg_rsp.err = reg_req.valid && (unmapped ||
                  (reg_req.write && (hit_status || hit_digest)) ||
                  (!reg_req.write && hit_ctrl));
  end

  // Commands while the core is busy are dropped
  assign cmd.init    = wr && hit_ctrl && reg_req.wdata[0] && core_ready;
  assign cmd.next    = wr && hit_ctrl && reg_req.wdata[1] && core_ready;
  assign cmd.zeroize = wr && hit_ctrl && reg_req.wdata[2];

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cmd.zeroize) begin
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        block_q[i] <= '0;
      end
    end else if (wr && hit_block) begin
      block_q[block_idx] <= reg_req.wdata;
    end
  end

  // Word 0 lands in the first message bits
  always_comb begin
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      block[1023 - 32*i -: 32] = block_q[i];
    end
  end

  assign digest_rise = core_digest_valid && !valid_d;

  always_ff @(posedge clk) begin
    if (cmd.zeroize) begin
      digest_q <= '0;
    end else if (digest_rise) begin
      digest_q <= core_digest;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_d <= 1'b0;
      done_q  <= 1'b0;
    end else if (cmd.zeroize) begin
      valid_d <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      valid_d <= core_digest_valid;
      // A new completion wins over a clear in the same cycle
      if (digest_rise) begin
        done_q <= 1'b1;
      end else if (wr && hit_intr && reg_req.wdata[0]) begin
        done_q <= 1'b0;
      end
    end
  end

  assign notif_intr = done_q;

endmodule

/* verilog/sha512_schedule.sv */
`timescale 1ns/100ps

module sha512_schedule (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      load,
  input  logic                      advance,
  input  logic                      zeroize,
  input  sha512_pkg::sha512_block_t block,
  output sha512_pkg::sha512_word_t  w
);
  import sha512_pkg::*;

  sha512_word_t w_q [16];
  sha512_word_t w_new;

  function automatic sha512_word_t sigma0(sha512_word_t x);
    return {x[0], x[63:1]} ^ {x[7:0], x[63:8]} ^ (x >> 7);
  endfunction

  function automatic sha512_word_t sigma1(sha512_word_t x);
    return {x[18:0], x[63:19]} ^ {x[60:0], x[63:61]} ^ (x >> 6);
  endfunction

  // W[t+16] from the window W[t] .. W[t+15]
  assign w_new = sigma1(w_q[14]) + w_q[9] + sigma0(w_q[1]) + w_q[0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 16; i++) begin
        w_q[i] <= '0;
      end
    end else if (zeroize) begin
      for (int i = 0; i < 16; i++) begin
        w_q[i] <= '0;
      end
    end else if (load) begin
      for (int i = 0; i < 16; i++) begin
        w_q[i] <= block[1023 - 64*i -: 64];
      end
    end else if (advance) begin
      for (int i = 0; i < 15; i++) begin
        w_q[i] <= w_q[i+1];
      end
      w_q[15] <= w_new;
    end
  end

  assign w = w_q[0];

endmodule
